// ==== hw/mpt_pkg.sv ====
// Widths, typedefs, encodings, field positions and the permission check of the table walker
package mpt_pkg;

    localparam int SPA_W   = 56;
    localparam int PPN_W   = 44;
    localparam int ENTRY_W = 64;
    localparam int SDID_W  = 6;
    localparam int MMPT_W  = 64;
    localparam int MODE_W  = 4;
    localparam int PERM_W  = 2;

    typedef logic [SPA_W-1:0]   spa_t;
    typedef logic [PPN_W-1:0]   ppn_t;
    typedef logic [ENTRY_W-1:0] entry_t;
    typedef logic [SDID_W-1:0]  sdid_t;
    typedef logic [MMPT_W-1:0]  mmpt_t;

    // Page-number fields of the SPA
    localparam int PN0_LSB = 12;
    localparam int PN0_W   = 4;
    localparam int PN1_LSB = 16;
    localparam int PN1_W   = 9;
    localparam int PN2_LSB = 25;
    localparam int PN2_W   = 21;

    // Protection register fields
    localparam int MMPT_PPN_LSB  = 0;
    localparam int MMPT_SDID_LSB = 44;
    localparam int MMPT_MODE_LSB = 60;

    // Entry layouts
    localparam int L2_INFO_W       = 44;
    localparam int L2_TYPE_LSB     = 44;
    localparam int L2_TYPE_W       = 3;
    localparam int L2_RSVD_LSB     = 47;
    localparam int L2_2M_RSVD_LSB  = 32;
    localparam int L1_RSVD_LSB     = 32;
    // Sixteen permission pairs per entry
    localparam int PERM_SEL_W      = 4;

    localparam spa_t SPA46_LIMIT = spa_t'(1) << 46;

    typedef enum logic [MODE_W-1:0] {
        MODE_BARE    = 4'd0,
        MODE_SMMPT46 = 4'd1
    } mode_e;

    typedef enum logic [1:0] {
        ACCESS_NONE  = 2'd0,
        ACCESS_READ  = 2'd1,
        ACCESS_WRITE = 2'd2,
        ACCESS_EXEC  = 2'd3
    } access_e;

    typedef enum logic [PERM_W-1:0] {
        PERM_NONE = 2'd0,
        PERM_RX   = 2'd1,
        PERM_RW   = 2'd2,
        PERM_RWX  = 2'd3
    } perm_e;

    typedef enum logic [L2_TYPE_W-1:0] {
        TYPE_DISALLOW   = 3'd0,
        TYPE_L1_DIR     = 3'd1,
        TYPE_2M_PAGES   = 3'd2,
        TYPE_ALLOW_RX   = 3'd3,
        TYPE_ALLOW_RW   = 3'd4,
        TYPE_ALLOW_RWX  = 3'd5
    } l2_type_e;

    typedef enum logic [2:0] {
        FAULT_NONE     = 3'd0,
        FAULT_BAD_ADDR = 3'd1,
        FAULT_RESERVED = 3'd2,
        FAULT_L2_INFO  = 3'd3,
        FAULT_L2_TYPE  = 3'd4
    } fault_e;

    function automatic logic perm_allows(perm_e perm, access_e access);
        case (access)
            ACCESS_READ:  return perm inside {PERM_RX, PERM_RW, PERM_RWX};
            ACCESS_WRITE: return perm inside {PERM_RW, PERM_RWX};
            ACCESS_EXEC:  return perm inside {PERM_RX, PERM_RWX};
            default:      return 1'b0;
        endcase
    endfunction

endpackage

// ==== hw/mpt_entry_decode.sv ====
// Decoder turning one level-2 or level-1 entry into a descend decision or a verdict
`timescale 1ns/1ns

module mpt_entry_decode import mpt_pkg::*; (
    input  entry_t              entry_i,
    input  logic                level_l1_i,
    input  logic [PN1_W-1:0]    pn1_i,
    input  logic [PN0_W-1:0]    pn0_i,
    input  access_e             access_i,
    output logic                descend_o,
    output ppn_t                next_addr_o,
    output logic                allow_o,
    output perm_e               perm_o,
    output logic                page_fault_o,
    output fault_e              fault_o
);

    logic [L2_INFO_W-1:0]  info;
    l2_type_e              l2_type;
    logic [PERM_SEL_W-1:0] page_2m;
    perm_e                 perm_sel;
    logic                  granted;
    logic                  disallow;

    assign info    = entry_i[L2_INFO_W-1:0];
    assign l2_type = l2_type_e'(entry_i[L2_TYPE_LSB +: L2_TYPE_W]);
    // Upper pn1 bits pick the 2 MiB page inside the 32 MiB range
    assign page_2m = pn1_i[PN1_W-1 -: PERM_SEL_W];

    always_comb begin
        descend_o   = 1'b0;
        next_addr_o = '0;
        fault_o     = FAULT_NONE;
        granted     = 1'b0;
        disallow    = 1'b0;
        perm_sel    = PERM_NONE;
        if (level_l1_i) begin
            if (entry_i[ENTRY_W-1:L1_RSVD_LSB] != '0) begin
                fault_o = FAULT_RESERVED;
            end else begin
                granted  = 1'b1;
                perm_sel = perm_e'(entry_i[{pn0_i, 1'b0} +: PERM_W]);
            end
        end else if (entry_i[ENTRY_W-1:L2_RSVD_LSB] != '0) begin
            fault_o = FAULT_RESERVED;
        end else begin
            case (l2_type)
                TYPE_DISALLOW, TYPE_ALLOW_RX, TYPE_ALLOW_RW, TYPE_ALLOW_RWX: begin
                    // Whole 32 MiB range, info must be clear
                    if (info != '0) begin
                        fault_o = FAULT_L2_INFO;
                    end else if (l2_type == TYPE_DISALLOW) begin
                        disallow = 1'b1;
                    end else begin
                        granted = 1'b1;
                        case (l2_type)
                            TYPE_ALLOW_RX: perm_sel = PERM_RX;
                            TYPE_ALLOW_RW: perm_sel = PERM_RW;
                            default:       perm_sel = PERM_RWX;
                        endcase
                    end
                end
                TYPE_L1_DIR: begin
                    descend_o   = 1'b1;
                    next_addr_o = info + ppn_t'(pn1_i);
                end
                TYPE_2M_PAGES: begin
                    if (info[L2_INFO_W-1:L2_2M_RSVD_LSB] != '0) begin
                        fault_o = FAULT_RESERVED;
                    end else begin
                        granted  = 1'b1;
                        perm_sel = perm_e'(info[{page_2m, 1'b0} +: PERM_W]);
                    end
                end
                default: fault_o = FAULT_L2_TYPE;
            endcase
        end
    end

    // One access check for every granted permission
    assign allow_o      = granted && perm_allows(perm_sel, access_i);
    assign page_fault_o = disallow || (granted && !allow_o);
    assign perm_o       = allow_o ? perm_sel : PERM_NONE;

endmodule

// ==== hw/mpt_request_check.sv ====
// Request intake with mode and address range check, launching a walk or finishing early
`timescale 1ns/1ns

module mpt_request_check import mpt_pkg::*; (
    input  logic    clk_i,
    input  logic    rst_ni,
    input  logic    ptw_enable_i,
    input  logic    addr_valid_i,
    input  spa_t    spa_i,
    input  access_e access_type_i,
    input  mmpt_t   mmpt_i,
    input  logic    result_valid_i,
    output logic    busy_o,
    output spa_t    spa_o,
    output access_e access_o,
    output sdid_t   sdid_o,
    output logic    walk_start_o,
    output ppn_t    root_addr_o,
    output logic    check_done_o,
    output logic    check_allow_o,
    output perm_e   check_perm_o,
    output fault_e  check_fault_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_CHECK,
        ST_WAIT
    } state_e;

    state_e  state_q;
    spa_t    spa_q;
    access_e access_q;
    sdid_t   sdid_q;
    ppn_t    root_q;
    mode_e   mode_q;
    logic    accept;

    assign accept = (state_q == ST_IDLE) && ptw_enable_i && addr_valid_i;

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (accept) begin
                        state_q <= ST_CHECK;
                    end
                end
                ST_CHECK: state_q <= ST_WAIT;
                ST_WAIT: begin
                    // Held until the verdict has been presented
                    if (result_valid_i) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            spa_q    <= spa_i;
            access_q <= access_type_i;
            sdid_q   <= mmpt_i[MMPT_SDID_LSB +: SDID_W];
            root_q   <= mmpt_i[MMPT_PPN_LSB +: PPN_W];
            mode_q   <= mode_e'(mmpt_i[MMPT_MODE_LSB +: MODE_W]);
        end
    end

    always_comb begin
        walk_start_o  = 1'b0;
        check_done_o  = 1'b0;
        check_allow_o = 1'b0;
        check_perm_o  = PERM_NONE;
        check_fault_o = FAULT_NONE;
        if (state_q == ST_CHECK) begin
            case (mode_q)
                MODE_BARE: begin
                    check_done_o  = 1'b1;
                    check_allow_o = 1'b1;
                    check_perm_o  = PERM_RWX;
                end
                MODE_SMMPT46: begin
                    if (spa_q >= SPA46_LIMIT) begin
                        check_done_o  = 1'b1;
                        check_fault_o = FAULT_BAD_ADDR;
                    end else begin
                        walk_start_o = 1'b1;
                    end
                end
                // Reserved mode codes, 56-bit included
                default: begin
                    check_done_o  = 1'b1;
                    check_fault_o = FAULT_RESERVED;
                end
            endcase
        end
    end

    // Level-2 entry lives at root plus pn2
    assign root_addr_o = root_q + ppn_t'(spa_q[PN2_LSB +: PN2_W]);

    assign busy_o   = (state_q != ST_IDLE);
    assign spa_o    = spa_q;
    assign access_o = access_q;
    assign sdid_o   = sdid_q;

    // A verdict only ever closes a request that is waiting for it
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        result_valid_i |-> state_q == ST_WAIT);

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(walk_start_o && check_done_o));

endmodule

// ==== hw/mpt_walk_fsm.sv ====
// Walk state machine driving the memory port, holding the fetched entry and the walk level
`timescale 1ns/1ns

module mpt_walk_fsm import mpt_pkg::*; (
    input  logic    clk_i,
    input  logic    rst_ni,
    input  logic    walk_start_i,
    input  ppn_t    root_addr_i,
    input  spa_t    spa_i,
    input  access_e access_i,
    input  logic    mem_gnt_i,
    input  logic    mem_rvalid_i,
    input  entry_t  mem_rdata_i,
    output logic    mem_req_o,
    output ppn_t    mem_addr_o,
    output logic    walk_done_o,
    output logic    walk_allow_o,
    output perm_e   walk_perm_o,
    output fault_e  walk_fault_o,
    output logic    walk_page_fault_o
);

    typedef enum logic [1:0] {
        W_IDLE,
        W_WAIT_GRANT,
        W_WAIT_RVALID,
        W_DECODE
    } state_e;

    state_e state_q;
    ppn_t   addr_q;
    entry_t entry_q;
    logic   level_l1_q;

    logic   dec_descend;
    ppn_t   dec_next_addr;
    logic   dec_allow;
    perm_e  dec_perm;
    logic   dec_page_fault;
    fault_e dec_fault;
    logic   descend;

    assign descend = (state_q == W_DECODE) && dec_descend;

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q <= W_IDLE;
        end else begin
            case (state_q)
                W_IDLE: begin
                    if (walk_start_i) begin
                        state_q <= W_WAIT_GRANT;
                    end
                end
                W_WAIT_GRANT: begin
                    if (mem_gnt_i) begin
                        state_q <= W_WAIT_RVALID;
                    end
                end
                W_WAIT_RVALID: begin
                    if (mem_rvalid_i) begin
                        state_q <= W_DECODE;
                    end
                end
                W_DECODE: state_q <= dec_descend ? W_WAIT_GRANT : W_IDLE;
                default:  state_q <= W_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (walk_start_i) begin
            addr_q     <= root_addr_i;
            level_l1_q <= 1'b0;
        end else if (descend) begin
            addr_q     <= dec_next_addr;
            level_l1_q <= 1'b1;
        end
        if ((state_q == W_WAIT_RVALID) && mem_rvalid_i) begin
            entry_q <= mem_rdata_i;
        end
    end

    mpt_entry_decode u_decode (
        .entry_i      (entry_q),
        .level_l1_i   (level_l1_q),
        .pn1_i        (spa_i[PN1_LSB +: PN1_W]),
        .pn0_i        (spa_i[PN0_LSB +: PN0_W]),
        .access_i     (access_i),
        .descend_o    (dec_descend),
        .next_addr_o  (dec_next_addr),
        .allow_o      (dec_allow),
        .perm_o       (dec_perm),
        .page_fault_o (dec_page_fault),
        .fault_o      (dec_fault)
    );

    assign mem_req_o  = (state_q == W_WAIT_GRANT);
    assign mem_addr_o = addr_q;

    // Verdict leaves in the decode cycle unless the walk goes down a level
    assign walk_done_o       = (state_q == W_DECODE) && !dec_descend;
    assign walk_allow_o      = walk_done_o && dec_allow;
    assign walk_perm_o       = walk_done_o ? dec_perm : PERM_NONE;
    assign walk_fault_o      = walk_done_o ? dec_fault : FAULT_NONE;
    assign walk_page_fault_o = walk_done_o && dec_page_fault;

    // Request held with a fixed address until granted
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_o && !mem_gnt_i |=> mem_req_o && $stable(mem_addr_o));

endmodule

// ==== hw/mpt_verdict_reg.sv ====
// Verdict register merging early-check and walk completions into a one-cycle result
`timescale 1ns/1ns

module mpt_verdict_reg import mpt_pkg::*; (
    input  logic   clk_i,
    input  logic   rst_ni,
    input  logic   check_done_i,
    input  logic   check_allow_i,
    input  perm_e  check_perm_i,
    input  fault_e check_fault_i,
    input  logic   walk_done_i,
    input  logic   walk_allow_i,
    input  perm_e  walk_perm_i,
    input  fault_e walk_fault_i,
    input  logic   walk_page_fault_i,
    input  spa_t   spa_i,
    input  sdid_t  sdid_i,
    output logic   ptw_valid_o,
    output logic   allow_o,
    output logic   access_page_fault_o,
    output fault_e format_error_o,
    output sdid_t  tlb_sdid_o,
    output spa_t   tlb_spa_o,
    output perm_e  tlb_perm_o
);

    logic   valid_q;
    logic   allow_q;
    logic   page_fault_q;
    perm_e  perm_q;
    fault_e fault_q;
    spa_t   spa_q;
    sdid_t  sdid_q;

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= check_done_i || walk_done_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (check_done_i || walk_done_i) begin
            spa_q  <= spa_i;
            sdid_q <= sdid_i;
            if (walk_done_i) begin
                allow_q      <= walk_allow_i;
                page_fault_q <= walk_page_fault_i;
                perm_q       <= walk_perm_i;
                fault_q      <= walk_fault_i;
            end else begin
                // Early finish never raises a page fault
                allow_q      <= check_allow_i;
                page_fault_q <= 1'b0;
                perm_q       <= check_perm_i;
                fault_q      <= check_fault_i;
            end
        end
    end

    assign ptw_valid_o         = valid_q;
    assign allow_o             = valid_q && allow_q;
    assign access_page_fault_o = valid_q && page_fault_q;
    assign format_error_o      = valid_q ? fault_q : FAULT_NONE;
    assign tlb_sdid_o          = valid_q ? sdid_q : '0;
    assign tlb_spa_o           = valid_q ? spa_q : '0;
    assign tlb_perm_o          = valid_q ? perm_q : PERM_NONE;

    // Busy drops right after the pulse, so no back-to-back verdicts
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        ptw_valid_o |=> !ptw_valid_o);

endmodule

// ==== hw/mpt_walker_top.sv ====
// Top level of the protection table walker connecting intake, walk and verdict blocks
`timescale 1ns/1ns

module mpt_walker_top import mpt_pkg::*; (
    input  logic    clk_i,
    input  logic    rst_ni,
    input  logic    ptw_enable_i,
    input  logic    addr_valid_i,
    input  spa_t    spa_i,
    input  access_e access_type_i,
    input  mmpt_t   mmpt_i,
    output logic    ptw_busy_o,
    output logic    ptw_valid_o,
    output logic    allow_o,
    output logic    access_page_fault_o,
    output fault_e  format_error_o,
    output sdid_t   tlb_sdid_o,
    output spa_t    tlb_spa_o,
    output perm_e   tlb_perm_o,
    output logic    mem_req_o,
    output ppn_t    mem_addr_o,
    input  logic    mem_gnt_i,
    input  logic    mem_rvalid_i,
    input  entry_t  mem_rdata_i
);

    spa_t    req_spa;
    access_e req_access;
    sdid_t   req_sdid;
    logic    walk_start;
    ppn_t    root_addr;
    logic    check_done;
    logic    check_allow;
    perm_e   check_perm;
    fault_e  check_fault;
    logic    walk_done;
    logic    walk_allow;
    perm_e   walk_perm;
    fault_e  walk_fault;
    logic    walk_page_fault;

    mpt_request_check u_request_check (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .ptw_enable_i   (ptw_enable_i),
        .addr_valid_i   (addr_valid_i),
        .spa_i          (spa_i),
        .access_type_i  (access_type_i),
        .mmpt_i         (mmpt_i),
        .result_valid_i (ptw_valid_o),
        .busy_o         (ptw_busy_o),
        .spa_o          (req_spa),
        .access_o       (req_access),
        .sdid_o         (req_sdid),
        .walk_start_o   (walk_start),
        .root_addr_o    (root_addr),
        .check_done_o   (check_done),
        .check_allow_o  (check_allow),
        .check_perm_o   (check_perm),
        .check_fault_o  (check_fault)
    );

    mpt_walk_fsm u_walk_fsm (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .walk_start_i      (walk_start),
        .root_addr_i       (root_addr),
        .spa_i             (req_spa),
        .access_i          (req_access),
        .mem_gnt_i         (mem_gnt_i),
        .mem_rvalid_i      (mem_rvalid_i),
        .mem_rdata_i       (mem_rdata_i),
        .mem_req_o         (mem_req_o),
        .mem_addr_o        (mem_addr_o),
        .walk_done_o       (walk_done),
        .walk_allow_o      (walk_allow),
        .walk_perm_o       (walk_perm),
        .walk_fault_o      (walk_fault),
        .walk_page_fault_o (walk_page_fault)
    );

    mpt_verdict_reg u_verdict_reg (
        .clk_i               (clk_i),
        .rst_ni              (rst_ni),
        .check_done_i        (check_done),
        .check_allow_i       (check_allow),
        .check_perm_i        (check_perm),
        .check_fault_i       (check_fault),
        .walk_done_i         (walk_done),
        .walk_allow_i        (walk_allow),
        .walk_perm_i         (walk_perm),
        .walk_fault_i        (walk_fault),
        .walk_page_fault_i   (walk_page_fault),
        .spa_i               (req_spa),
        .sdid_i              (req_sdid),
        .ptw_valid_o         (ptw_valid_o),
        .allow_o             (allow_o),
        .access_page_fault_o (access_page_fault_o),
        .format_error_o      (format_error_o),
        .tlb_sdid_o          (tlb_sdid_o),
        .tlb_spa_o           (tlb_spa_o),
        .tlb_perm_o          (tlb_perm_o)
    );

endmodule

// ==== verification/mpt_mem_model.sv ====
// Table memory model with programmable grant and read-valid delays
`timescale 1ns/1ns

module mpt_mem_model import mpt_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_ni,
    input  logic       mem_req_i,
    input  ppn_t       mem_addr_i,
    input  logic [1:0] gnt_delay_i,
    input  logic [1:0] rvalid_delay_i,
    output logic       mem_gnt_o,
    output logic       mem_rvalid_o,
    output entry_t     mem_rdata_o
);

    // Sparse table contents, written directly by the testbench
    entry_t     mem [ppn_t];
    logic [1:0] gnt_cnt;
    logic [1:0] rv_cnt;
    logic       pending;
    ppn_t       addr_q;

    // Only one access outstanding, so no grant while a read is pending
    assign mem_gnt_o = mem_req_i && !pending && (gnt_cnt == gnt_delay_i);

    always @(posedge clk_i) begin
        if (!rst_ni) begin
            gnt_cnt      <= '0;
            rv_cnt       <= '0;
            pending      <= 1'b0;
            mem_rvalid_o <= 1'b0;
            mem_rdata_o  <= '0;
        end else begin
            mem_rvalid_o <= 1'b0;
            if (mem_gnt_o) begin
                gnt_cnt <= '0;
                rv_cnt  <= 2'd1;
                pending <= 1'b1;
                addr_q  <= mem_addr_i;
            end else if (mem_req_i && !pending) begin
                gnt_cnt <= gnt_cnt + 2'd1;
            end
            if (pending) begin
                if (rv_cnt >= rvalid_delay_i) begin
                    mem_rvalid_o <= 1'b1;
                    mem_rdata_o  <= mem.exists(addr_q) ? mem[addr_q] : '0;
                    pending      <= 1'b0;
                end else begin
                    rv_cnt <= rv_cnt + 2'd1;
                end
            end
        end
    end

endmodule

// ==== verification/mpt_walker_tb.sv ====
// Testbench for the table walker with reference model, stimulus, checker and timeout
`timescale 1ns/1ns

module mpt_walker_tb import mpt_pkg::*; ();

    localparam int N_BARE  = 8;
    localparam int N_FAULT = 8;
    localparam int N_L2    = 28;
    localparam int N_2M    = 16;
    localparam int N_L1    = 24;
    localparam int TOTAL_REQ  = N_BARE + N_FAULT + N_L2 + N_2M + N_L1;
    localparam int MAX_CYCLES = 10 + 60 * TOTAL_REQ;
    localparam ppn_t ROOT = 44'h0000_0001_0000;

    logic clk_i = 1'b0;
    logic rst_ni;
    logic ptw_enable_i, addr_valid_i;
    spa_t spa_i;
    access_e access_type_i;
    mmpt_t mmpt_i;
    logic ptw_busy_o, ptw_valid_o, allow_o, access_page_fault_o;
    fault_e format_error_o;
    sdid_t tlb_sdid_o;
    spa_t tlb_spa_o;
    perm_e tlb_perm_o;
    logic mem_req_o, mem_gnt_i, mem_rvalid_i;
    ppn_t mem_addr_o;
    entry_t mem_rdata_i;
    logic [1:0] gnt_delay, rv_delay;

    logic [31:0] lfsr_q;
    entry_t tbl [ppn_t];
    int cycle_cnt = 0;
    int issue_cycle, issued, done_count;
    logic pending, exp_fixed, prev_valid;
    logic [6:0] exp_verdict;
    spa_t exp_spa;
    sdid_t exp_sdid;
    string test_name;

    always #20 clk_i = ~clk_i;

    mpt_walker_top u_dut (.*);

    mpt_mem_model u_mem (
        .clk_i(clk_i), .rst_ni(rst_ni), .mem_req_i(mem_req_o), .mem_addr_i(mem_addr_o),
        .gnt_delay_i(gnt_delay), .rvalid_delay_i(rv_delay),
        .mem_gnt_o(mem_gnt_i), .mem_rvalid_o(mem_rvalid_i), .mem_rdata_o(mem_rdata_i)
    );

    // Taps 32, 22, 2, 1; one step per random bit
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
            v = {v[62:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic entry_t read_tbl(input ppn_t a);
        return tbl.exists(a) ? tbl[a] : '0;
    endfunction

    task automatic put_entry(input ppn_t a, input entry_t v);
        tbl[a] = v;
        u_mem.mem[a] = v;
    endtask

    function automatic logic access_ok(input logic [1:0] p, input logic [1:0] a);
        case (a)
            2'd1: return p != 2'd0;
            2'd2: return p[1];
            2'd3: return p[0];
            default: return 1'b0;
        endcase
    endfunction

    // Result packed as allow, page fault, fault cause, permission
    function automatic logic [6:0] ref_verdict(input mmpt_t m, input spa_t s, input logic [1:0] a);
        entry_t e2;
        entry_t e1;
        logic [43:0] info;
        logic [2:0] typ;
        logic [2:0] fault;
        logic [1:0] p;
        logic granted;
        logic pf;
        int idx;
        granted = 1'b0;
        pf = 1'b0;
        fault = 3'd0;
        p = 2'd0;
        if (m[63:60] == 4'd0) return {2'b10, 3'd0, 2'd3};
        if (m[63:60] != 4'd1) return {2'b00, 3'd2, 2'd0};
        if (s[55:46] != '0) return {2'b00, 3'd1, 2'd0};
        e2 = read_tbl(m[43:0] + ppn_t'(s[45:25]));
        info = e2[43:0];
        typ = e2[46:44];
        if (e2[63:47] != '0) begin
            fault = 3'd2;
        end else if (typ == 3'd0 || (typ >= 3'd3 && typ <= 3'd5)) begin
            if (info != '0) fault = 3'd3;
            else if (typ == 3'd0) pf = 1'b1;
            else begin
                granted = 1'b1;
                p = 2'(typ - 3'd2);
            end
        end else if (typ == 3'd1) begin
            e1 = read_tbl(info + ppn_t'(s[24:16]));
            idx = 2 * int'(s[15:12]);
            if (e1[63:32] != '0) fault = 3'd2;
            else begin
                granted = 1'b1;
                p = e1[idx +: 2];
            end
        end else if (typ == 3'd2) begin
            idx = 2 * int'(s[24:21]);
            if (info[43:32] != '0) fault = 3'd2;
            else begin
                granted = 1'b1;
                p = info[idx +: 2];
            end
        end else begin
            fault = 3'd4;
        end
        if (granted && access_ok(p, a)) return {2'b10, 3'd0, p};
        return {1'b0, pf || granted, fault, 2'd0};
    endfunction

    task automatic end_with_failure();
        $display("Checks failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string test, input string field,
                               input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            $display("mismatch %s %s expected %0h actual %0h", test, field, exp, act);
            end_with_failure();
        end
    endtask

    // Outputs are stable at the falling edge
    always @(negedge clk_i) begin
        if (rst_ni) begin
            // Busy from the accepting edge through the verdict cycle
            check_value(test_name, "busy", 64'(pending && (cycle_cnt != issue_cycle)),
                        64'(ptw_busy_o));
            if (ptw_valid_o) begin
                if (prev_valid) begin
                    $display("ptw_valid_o stayed high for two cycles in %s", test_name);
                    end_with_failure();
                end
                if (!pending) begin
                    $display("ptw_valid_o pulsed without an outstanding request");
                    end_with_failure();
                end
                check_value(test_name, "allow", 64'(exp_verdict[6]), 64'(allow_o));
                check_value(test_name, "page_fault", 64'(exp_verdict[5]),
                            64'(access_page_fault_o));
                check_value(test_name, "cause", 64'(exp_verdict[4:2]), 64'(format_error_o));
                check_value(test_name, "perm", 64'(exp_verdict[1:0]), 64'(tlb_perm_o));
                check_value(test_name, "spa", 64'(exp_spa), 64'(tlb_spa_o));
                check_value(test_name, "sdid", 64'(exp_sdid), 64'(tlb_sdid_o));
                if (exp_fixed) begin
                    check_value(test_name, "latency", 64'(2), 64'(cycle_cnt - issue_cycle));
                end
                pending = 1'b0;
                done_count++;
            end else begin
                check_value(test_name, "idle allow", 64'(0), 64'(allow_o));
                check_value(test_name, "idle page_fault", 64'(0), 64'(access_page_fault_o));
                check_value(test_name, "idle cause", 64'(0), 64'(format_error_o));
                check_value(test_name, "idle perm", 64'(0), 64'(tlb_perm_o));
                check_value(test_name, "idle spa", 64'(0), 64'(tlb_spa_o));
                check_value(test_name, "idle sdid", 64'(0), 64'(tlb_sdid_o));
                if (!pending) begin
                    check_value(test_name, "idle mem_req", 64'(0), 64'(mem_req_o));
                end
            end
            prev_valid = ptw_valid_o;
        end
    end

    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt > MAX_CYCLES) begin
            $display("timeout after %0d cycles with a request still open", cycle_cnt);
            end_with_failure();
        end
    end

    task automatic run_request(input string name, input mmpt_t m, input spa_t s,
                               input logic [1:0] a, input logic fixed);
        @(negedge clk_i);
        gnt_delay = 2'(rand_bits(2));
        rv_delay = 2'(rand_bits(2));
        if (rv_delay == 2'd0) rv_delay = 2'd1;
        exp_verdict = ref_verdict(m, s, a);
        exp_spa = s;
        exp_sdid = m[49:44];
        exp_fixed = fixed;
        test_name = name;
        issue_cycle = cycle_cnt;
        pending = 1'b1;
        issued++;
        ptw_enable_i = 1'b1;
        addr_valid_i = 1'b1;
        spa_i = s;
        access_type_i = access_e'(a);
        mmpt_i = m;
        @(negedge clk_i);
        ptw_enable_i = 1'b0;
        addr_valid_i = 1'b0;
        // A request while busy must be ignored
        if (rand_bits(1) == 64'd1 && ptw_busy_o && !ptw_valid_o) begin
            spa_i = spa_t'(rand_bits(56));
            ptw_enable_i = 1'b1;
            addr_valid_i = 1'b1;
            @(negedge clk_i);
            ptw_enable_i = 1'b0;
            addr_valid_i = 1'b0;
        end
        @(posedge clk_i);
        while (done_count != issued) @(posedge clk_i);
    endtask

    function automatic mmpt_t make_mmpt(input logic [3:0] mode);
        return {mode, 10'd0, 6'(rand_bits(6)), ROOT};
    endfunction

    initial begin
        spa_t s;
        logic [2:0] typ;
        logic [43:0] info;
        logic [16:0] rsvd;
        logic [3:0] mode;
        ppn_t dir;
        lfsr_q = 32'hcc0a_fa25;
        rst_ni = 1'b0;
        ptw_enable_i = 1'b0;
        addr_valid_i = 1'b0;
        spa_i = '0;
        access_type_i = ACCESS_NONE;
        mmpt_i = '0;
        gnt_delay = 2'd0;
        rv_delay = 2'd1;
        issued = 0;
        done_count = 0;
        pending = 1'b0;
        prev_valid = 1'b0;
        test_name = "reset";
        repeat (10) @(negedge clk_i);
        rst_ni = 1'b1;
        for (int i = 0; i < N_BARE; i++) begin
            run_request("bare", make_mmpt(4'd0), spa_t'(rand_bits(56)), 2'(rand_bits(2)), 1'b1);
        end
        for (int i = 0; i < N_FAULT; i++) begin
            if (i < N_FAULT / 2) begin
                s = spa_t'(rand_bits(56)) | SPA46_LIMIT;
                run_request("bad_addr", make_mmpt(4'd1), s, 2'(rand_bits(2)), 1'b1);
            end else begin
                mode = 4'(rand_bits(4));
                if (mode < 4'd2) mode = mode + 4'd2;
                run_request("bad_mode", make_mmpt(mode), spa_t'(rand_bits(46)),
                            2'(rand_bits(2)), 1'b1);
            end
        end
        for (int i = 0; i < N_L2; i++) begin
            s = spa_t'(rand_bits(46));
            typ = 3'(rand_bits(2));
            if (i >= N_L2 - 4) typ = 3'd6 + 3'(rand_bits(1));
            else if (typ != 3'd0) typ = typ + 3'd2;
            info = (rand_bits(2) == 64'd0) ? 44'(rand_bits(44)) : 44'd0;
            rsvd = (rand_bits(3) == 64'd0) ? 17'(rand_bits(17)) : 17'd0;
            put_entry(ROOT + ppn_t'(s[45:25]), {rsvd, typ, info});
            run_request("l2_type", make_mmpt(4'd1), s, 2'(rand_bits(2)), 1'b0);
        end
        for (int i = 0; i < N_2M; i++) begin
            s = spa_t'(rand_bits(46));
            info[43:32] = (rand_bits(2) == 64'd0) ? 12'(rand_bits(12)) : 12'd0;
            info[31:0] = 32'(rand_bits(32));
            put_entry(ROOT + ppn_t'(s[45:25]), {17'd0, 3'd2, info});
            run_request("l2_2m", make_mmpt(4'd1), s, 2'(rand_bits(2)), 1'b0);
        end
        for (int i = 0; i < N_L1; i++) begin
            s = spa_t'(rand_bits(46));
            dir = ppn_t'(rand_bits(30));
            put_entry(ROOT + ppn_t'(s[45:25]), {17'd0, 3'd1, dir});
            put_entry(dir + ppn_t'(s[24:16]),
                      {(rand_bits(3) == 64'd0) ? 32'(rand_bits(32)) : 32'd0,
                       32'(rand_bits(32))});
            run_request("l1_page", make_mmpt(4'd1), s, 2'(rand_bits(2)), 1'b0);
        end
        repeat (4) @(negedge clk_i);
        if (done_count == TOTAL_REQ) begin
            $display("All checks passed");
            $finish;
        end else begin
            $display("%0d of %0d requests completed", done_count, TOTAL_REQ);
            end_with_failure();
        end
    end

endmodule

// ==== flist.f ====
hw/mpt_pkg.sv
hw/mpt_entry_decode.sv
hw/mpt_request_check.sv
hw/mpt_walk_fsm.sv
hw/mpt_verdict_reg.sv
hw/mpt_walker_top.sv
verification/mpt_mem_model.sv
verification/mpt_walker_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert
TOP       ?= mpt_walker_tb
FLIST     ?= flist.f
LOG       ?= sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "Checks failed" $(LOG); then exit 1; fi
	@grep -q "All checks passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
